// File: list.f
+incdir+verilog
verilog/sfp_led_pkg.sv
verilog/blink_gen.sv
verilog/activity_window.sv
verilog/sfp_port_leds.sv
verilog/sfp_led_top.sv
test/tb_sfp_led.sv

// File: Makefile
# Verilator build and run of the SFP+ LED testbench
# Override any variable on the command line, e.g. make sim LOG=run.log

VERILATOR ?= verilator
TOP       ?= tb_sfp_led
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  ?= tests failed
PASS_MSG  ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; \
		exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; \
		exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_sfp_led.sv
// Testbench for the SFP+ link and activity LED top level.
// Runs directed phases and an LFSR random phase against a reference model,
// with concurrent assertions comparing every LED on each clock.

`timescale 1ns/1ps

`include "sfp_led_defs.svh"

module tb_sfp_led;

    localparam int BLINK_H  = 4;     // Blink half-period in cycles
    localparam int WINDOW_W = 20;    // Activity window parameter

    // ------------------------------------------------------------------
    // Phase lengths and run limit
    // ------------------------------------------------------------------

    localparam int RESET_CYCLES = 5;
    localparam int T_IDLE       = 16;
    localparam int T_SINGLE     = WINDOW_W + 12;
    localparam int T_RETRIG     = WINDOW_W / 2 + WINDOW_W + 14;
    localparam int T_HELD       = 3 * WINDOW_W + 12;
    localparam int T_LOCK       = WINDOW_W + 16;
    localparam int T_RANDOM     = 1500;
    localparam int CYCLE_LIMIT  = RESET_CYCLES + T_IDLE + T_SINGLE + T_RETRIG + T_HELD
                                  + T_LOCK + T_RANDOM + 100;

    logic                     clk_125mhz_int;
    logic                     sfp_reset_in;
    logic [`SFP_PORTS-1:0]    block_lock;
    sfp_led_pkg::xgmii_ctrl_t txc [`SFP_PORTS];
    sfp_led_pkg::xgmii_ctrl_t rxc [`SFP_PORTS];
    sfp_led_pkg::led_pair_t   led [`SFP_PORTS];

    string       test_name = "reset";
    int          mismatch_cnt = 0;
    int          other_cnt = 0;
    logic [31:0] lfsr_q = 32'h6dfe;

    sfp_led_top #(
        .BLINK_HALF_CYCLES    (BLINK_H),
        .ACTIVE_WINDOW_CYCLES (WINDOW_W)
    ) i_dut (
        .clk_125mhz_int (clk_125mhz_int),
        .sfp_reset_in   (sfp_reset_in),
        .block_lock_i   (block_lock),
        .xgmii_txc_i    (txc),
        .xgmii_rxc_i    (rxc),
        .led_o          (led)
    );

    initial begin
        clk_125mhz_int = 1'b0;
        forever #4 clk_125mhz_int = ~clk_125mhz_int;
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------

    int   edge_cnt;                      // Edges since reset release
    logic prev_tx [`SFP_PORTS];
    logic prev_rx [`SFP_PORTS];
    int   left_tx [`SFP_PORTS];          // Window cycles still to blink
    int   left_rx [`SFP_PORTS];
    logic blink_exp;
    sfp_led_pkg::led_pair_t led_exp [`SFP_PORTS];

    function automatic logic has_data(input sfp_led_pkg::xgmii_ctrl_t c);
        return c != {`XGMII_LANES{1'b1}};  // Any zero control bit
    endfunction

    always @(posedge clk_125mhz_int or posedge sfp_reset_in) begin
        if (sfp_reset_in) begin
            edge_cnt <= 0;
            for (int p = 0; p < `SFP_PORTS; p++) begin
                prev_tx[p] <= 1'b0;
                prev_rx[p] <= 1'b0;
                left_tx[p] <= 0;
                left_rx[p] <= 0;
            end
        end else begin
            edge_cnt <= edge_cnt + 1;
            for (int p = 0; p < `SFP_PORTS; p++) begin
                prev_tx[p] <= has_data(txc[p]);
                prev_rx[p] <= has_data(rxc[p]);
                if (has_data(txc[p]) && !prev_tx[p]) left_tx[p] <= WINDOW_W + 1;
                else if (left_tx[p] > 0)              left_tx[p] <= left_tx[p] - 1;
                if (has_data(rxc[p]) && !prev_rx[p]) left_rx[p] <= WINDOW_W + 1;
                else if (left_rx[p] > 0)              left_rx[p] <= left_rx[p] - 1;
            end
        end
    end

    assign blink_exp = ((edge_cnt / BLINK_H) % 2) == 1;

    always_comb begin
        for (int p = 0; p < `SFP_PORTS; p++) begin
            led_exp[p][0] = block_lock[p] & ((left_tx[p] > 0) ? blink_exp : 1'b1);
            led_exp[p][1] = block_lock[p] & ((left_rx[p] > 0) ? blink_exp : 1'b1);
        end
    end

    // ------------------------------------------------------------------
    // LED checks, on the falling edge where everything is settled
    // ------------------------------------------------------------------

    for (genvar p = 0; p < `SFP_PORTS; p++) begin : g_check
        tx_led_a : assert property (@(negedge clk_125mhz_int) disable iff (sfp_reset_in)
            led[p][0] == led_exp[p][0])
        else begin
            mismatch_cnt++;
            $display("mismatch %s: port %0d TX LED expected %b actual %b",
                     test_name, p, led_exp[p][0], led[p][0]);
        end

        rx_led_a : assert property (@(negedge clk_125mhz_int) disable iff (sfp_reset_in)
            led[p][1] == led_exp[p][1])
        else begin
            mismatch_cnt++;
            $display("mismatch %s: port %0d RX LED expected %b actual %b",
                     test_name, p, led_exp[p][1], led[p][1]);
        end
    end

    // ------------------------------------------------------------------
    // Stimulus helpers
    // ------------------------------------------------------------------

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    task automatic take_bits(input int n, output logic [31:0] bits);
        bits = '0;
        for (int i = 0; i < n; i++) begin
            bits[i] = lfsr_q[0];
            lfsr_q  = lfsr_next(lfsr_q);   // One step per bit
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_125mhz_int);
        #1;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) next_cycle();
    endtask

    // Mostly idle lanes, one cycle in four carries random bytes
    task automatic random_ctrl(output sfp_led_pkg::xgmii_ctrl_t c);
        logic [31:0] bits;
        take_bits(2, bits);
        c = '1;
        if (bits[1:0] == 2'b00) begin
            take_bits(`XGMII_LANES, bits);
            c = bits[`XGMII_LANES-1:0];
        end
    endtask

    task automatic random_cycle();
        logic [31:0] bits;
        for (int p = 0; p < `SFP_PORTS; p++) begin
            take_bits(4, bits);
            if (bits[3:0] == 4'hf) block_lock[p] = ~block_lock[p];  // Rare lock flips
            random_ctrl(txc[p]);
            random_ctrl(rxc[p]);
        end
        next_cycle();
    endtask

    // ------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------

    initial begin
        int low_cnt;
        sfp_reset_in = 1'b1;
        block_lock   = '0;
        for (int p = 0; p < `SFP_PORTS; p++) begin
            txc[p] = '1;
            rxc[p] = '1;
        end
        repeat (RESET_CYCLES) @(posedge clk_125mhz_int);
        #1;
        sfp_reset_in = 1'b0;

        test_name  = "reset_idle";
        block_lock = 4'b1011;              // Port 2 without lock
        idle_cycles(T_IDLE);

        test_name  = "single_event";
        block_lock = '1;
        txc[2]     = 8'hfe;                // One data lane for one cycle
        next_cycle();
        txc[2]  = '1;
        low_cnt = 0;
        for (int i = 0; i < T_SINGLE - 1; i++) begin
            if (led[2][0] == 1'b0) low_cnt++;
            next_cycle();
        end
        no_blink_a : assert (low_cnt > 0)
        else begin
            other_cnt++;
            $display("port 2 TX LED never went dark during its activity window");
        end

        test_name = "retrigger";
        txc[2]    = 8'h00;
        next_cycle();
        txc[2] = '1;
        idle_cycles(WINDOW_W / 2);
        txc[2] = 8'h7f;                    // Second event inside the window
        next_cycle();
        txc[2] = '1;
        idle_cycles(T_RETRIG - WINDOW_W / 2 - 2);

        test_name = "held_data";
        txc[2]    = 8'h00;
        rxc[1]    = 8'h3c;
        idle_cycles(3 * WINDOW_W);         // Data never stops
        txc[2] = '1;
        rxc[1] = '1;
        idle_cycles(T_HELD - 3 * WINDOW_W);

        test_name = "lock_drop";
        txc[3]    = 8'h0f;
        rxc[3]    = 8'hf0;
        next_cycle();
        txc[3] = '1;
        rxc[3] = '1;
        idle_cycles(4);
        block_lock[3] = 1'b0;              // Windows still open here
        idle_cycles(6);
        block_lock[3] = 1'b1;
        idle_cycles(T_LOCK - 11);

        test_name = "random";
        repeat (T_RANDOM) random_cycle();
        for (int p = 0; p < `SFP_PORTS; p++) begin
            txc[p] = '1;
            rxc[p] = '1;
        end
        idle_cycles(2);                    // Let the last checks fire

        $display("errors: %0d LED mismatches, %0d other failures", mismatch_cnt, other_cnt);
        if (mismatch_cnt == 0 && other_cnt == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // Watchdog against a stuck run
    initial begin
        repeat (CYCLE_LIMIT) @(posedge clk_125mhz_int);
        $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("tests failed");
        $finish;
    end

endmodule

// File: verilog/sfp_led_top.sv
// Link and activity LEDs for the four SFP+ ports of a 10G board.
// Feed each port's RX block lock and its XGMII TX and RX control
// lanes, all in the clk_125mhz_int domain. led_o[p] bit 0 drives the
// TX LED of port p, bit 1 its RX LED.

`timescale 1ns/1ps

`include "sfp_led_defs.svh"

module sfp_led_top #(
    parameter int unsigned BLINK_HALF_CYCLES    = `BLINK_HALF_CYCLES,
    parameter int unsigned ACTIVE_WINDOW_CYCLES = `ACTIVE_WINDOW_CYCLES
) (
    input  logic                     clk_125mhz_int,
    input  logic                     sfp_reset_in,

    // Per-port status and XGMII control lanes
    input  logic [`SFP_PORTS-1:0]    block_lock_i,
    input  sfp_led_pkg::xgmii_ctrl_t xgmii_txc_i [`SFP_PORTS],
    input  sfp_led_pkg::xgmii_ctrl_t xgmii_rxc_i [`SFP_PORTS],

    // Per-port LED pairs
    output sfp_led_pkg::led_pair_t   led_o [`SFP_PORTS]
);

    // ------------------------------------------------------------------
    // Shared blink source
    // ------------------------------------------------------------------

    logic blink;    // Common to all ports so the LEDs stay in phase

    blink_gen #(
        .HALF_CYCLES (BLINK_HALF_CYCLES)
    ) i_blink_gen (
        .clk_125mhz_int (clk_125mhz_int),
        .sfp_reset_in   (sfp_reset_in),
        .blink_o        (blink)
    );

    // ------------------------------------------------------------------
    // One LED block per port
    // ------------------------------------------------------------------

    for (genvar p = 0; p < `SFP_PORTS; p++) begin : g_port
        sfp_port_leds #(
            .WINDOW_CYCLES (ACTIVE_WINDOW_CYCLES)
        ) i_port_leds (
            .clk_125mhz_int (clk_125mhz_int),
            .sfp_reset_in   (sfp_reset_in),
            .block_lock_i   (block_lock_i[p]),
            .txc_i          (xgmii_txc_i[p]),
            .rxc_i          (xgmii_rxc_i[p]),
            .blink_i        (blink),
            .led_o          (led_o[p])
        );
    end

endmodule

// File: verilog/sfp_port_leds.sv
// LED pair of one SFP+ port.
// Off without block lock, steady on when idle, and following the
// shared blink while that direction's activity window is open.
// The LED path itself is combinational.

`timescale 1ns/1ps

`include "sfp_led_defs.svh"

module sfp_port_leds #(
    parameter int unsigned WINDOW_CYCLES = `ACTIVE_WINDOW_CYCLES
) (
    input  logic                     clk_125mhz_int,
    input  logic                     sfp_reset_in,
    input  logic                     block_lock_i,
    input  sfp_led_pkg::xgmii_ctrl_t txc_i,
    input  sfp_led_pkg::xgmii_ctrl_t rxc_i,
    input  logic                     blink_i,
    output sfp_led_pkg::led_pair_t   led_o
);

    // ------------------------------------------------------------------
    // Per-direction activity windows
    // ------------------------------------------------------------------

    logic tx_blink_en;
    logic rx_blink_en;

    activity_window #(
        .WINDOW_CYCLES (WINDOW_CYCLES)
    ) i_tx_window (
        .clk_125mhz_int (clk_125mhz_int),
        .sfp_reset_in   (sfp_reset_in),
        .ctrl_i         (txc_i),
        .blink_en_o     (tx_blink_en)
    );

    activity_window #(
        .WINDOW_CYCLES (WINDOW_CYCLES)
    ) i_rx_window (
        .clk_125mhz_int (clk_125mhz_int),
        .sfp_reset_in   (sfp_reset_in),
        .ctrl_i         (rxc_i),
        .blink_en_o     (rx_blink_en)
    );

    // ------------------------------------------------------------------
    // LED policy
    // ------------------------------------------------------------------

    logic tx_level;
    logic rx_level;

    // Blink while active, otherwise steady
    assign tx_level = tx_blink_en ? blink_i : 1'b1;
    assign rx_level = rx_blink_en ? blink_i : 1'b1;

    // Lock gates both LEDs, even with a window open
    assign led_o[0] = block_lock_i & tx_level;  // TX
    assign led_o[1] = block_lock_i & rx_level;  // RX

endmodule

// File: verilog/activity_window.sv
// Activity detector for one XGMII direction.
// A rising edge of "any lane carries data" opens a window of
// WINDOW_CYCLES+1 cycles, and blink_en_o is high while it is open.
// A new event inside the window restarts it.

`timescale 1ns/1ps

`include "sfp_led_defs.svh"

module activity_window #(
    parameter int unsigned WINDOW_CYCLES = `ACTIVE_WINDOW_CYCLES
) (
    input  logic                     clk_125mhz_int,
    input  logic                     sfp_reset_in,
    input  sfp_led_pkg::xgmii_ctrl_t ctrl_i,
    output logic                     blink_en_o
);

    localparam sfp_led_pkg::cycle_cnt_t LAST_CNT = sfp_led_pkg::cycle_cnt_t'(WINDOW_CYCLES);

    // ------------------------------------------------------------------
    // Event detection
    // ------------------------------------------------------------------

    logic data_now;     // Some lane holds a data byte
    logic data_prev_q;
    logic act_event;

    assign data_now  = |(~ctrl_i);
    assign act_event = data_now & ~data_prev_q;  // Held data does not retrigger

    always_ff @(posedge clk_125mhz_int or posedge sfp_reset_in) begin
        if (sfp_reset_in) begin
            data_prev_q <= 1'b0;
        end else begin
            data_prev_q <= data_now;
        end
    end

    // ------------------------------------------------------------------
    // Window FSM
    // ------------------------------------------------------------------

    sfp_led_pkg::window_state_t state_q, state_d;
    sfp_led_pkg::cycle_cnt_t    timer_q, timer_d;

    always_comb begin
        state_d = state_q;
        timer_d = timer_q;
        if (act_event) begin
            state_d = sfp_led_pkg::WIN_BLINK;  // Open or restart
            timer_d = '0;
        end else if (state_q == sfp_led_pkg::WIN_BLINK) begin
            if (timer_q == LAST_CNT) begin
                state_d = sfp_led_pkg::WIN_IDLE;
            end else begin
                timer_d = timer_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk_125mhz_int or posedge sfp_reset_in) begin
        if (sfp_reset_in) begin
            state_q <= sfp_led_pkg::WIN_IDLE;
            timer_q <= '0;
        end else begin
            state_q <= state_d;
            timer_q <= timer_d;
        end
    end

    assign blink_en_o = (state_q == sfp_led_pkg::WIN_BLINK);

endmodule

// File: verilog/blink_gen.sv
// Free-running square wave shared by all activity LEDs.
// One instance per design, so every port blinks in phase.
// HALF_CYCLES sets the length of each high and low phase.

`timescale 1ns/1ps

`include "sfp_led_defs.svh"

module blink_gen #(
    parameter int unsigned HALF_CYCLES = `BLINK_HALF_CYCLES
) (
    input  logic clk_125mhz_int,
    input  logic sfp_reset_in,
    output logic blink_o
);

    // ------------------------------------------------------------------
    // Half-period counter
    // ------------------------------------------------------------------

    localparam sfp_led_pkg::cycle_cnt_t LAST_CNT = sfp_led_pkg::cycle_cnt_t'(HALF_CYCLES - 1);

    sfp_led_pkg::cycle_cnt_t half_cnt_q;
    logic                    half_done;
    logic                    blink_q;

    assign half_done = (half_cnt_q == LAST_CNT);  // Last cycle of a phase

    always_ff @(posedge clk_125mhz_int or posedge sfp_reset_in) begin
        if (sfp_reset_in) begin
            half_cnt_q <= '0;
        end else if (half_done) begin
            half_cnt_q <= '0;
        end else begin
            half_cnt_q <= half_cnt_q + 1'b1;
        end
    end

    // ------------------------------------------------------------------
    // Output toggle
    // ------------------------------------------------------------------

    // Starts low, first toggle on the HALF_CYCLES-th edge after reset
    always_ff @(posedge clk_125mhz_int or posedge sfp_reset_in) begin
        if (sfp_reset_in) begin
            blink_q <= 1'b0;
        end else if (half_done) begin
            blink_q <= ~blink_q;
        end
    end

    assign blink_o = blink_q;

endmodule

// File: verilog/sfp_led_pkg.sv
// Types shared by the SFP+ LED logic and its testbench.
// Referenced by scoped names, compile ahead of the RTL.

`include "sfp_led_defs.svh"

package sfp_led_pkg;

    // ------------------------------------------------------------------
    // Vector types
    // ------------------------------------------------------------------

    // XGMII control bits of one direction, a 0 marks a data byte
    typedef logic [`XGMII_LANES-1:0] xgmii_ctrl_t;

    // Bit 0 is the TX LED, bit 1 the RX LED
    typedef logic [1:0] led_pair_t;

    typedef logic [`CNT_BITS-1:0] cycle_cnt_t;  // Blink and window timers

    // ------------------------------------------------------------------
    // State machines
    // ------------------------------------------------------------------

    // Activity window of one direction
    typedef enum logic {
        WIN_IDLE  = 1'b0,   // No recent activity, LED steady
        WIN_BLINK = 1'b1    // Window open, LED follows blink
    } window_state_t;

endpackage

// File: verilog/sfp_led_defs.svh
// Shared sizes and default timing for the SFP+ link and activity LEDs.
// Include wherever a port count, lane count or timing default is needed.
// The timing values assume the 125 MHz system clock.

`ifndef SFP_LED_DEFS_SVH
`define SFP_LED_DEFS_SVH

// ----------------------------------------------------------------------
// Sizes
// ----------------------------------------------------------------------

`define SFP_PORTS            4          // SFP+ cages on the board
`define XGMII_LANES          8          // Control bits per XGMII direction

// ----------------------------------------------------------------------
// Timing defaults, in clk_125mhz_int cycles
// ----------------------------------------------------------------------

// 5 Hz blink, 100 ms per half-period
`define BLINK_HALF_CYCLES    12500000

`define ACTIVE_WINDOW_CYCLES 125000000  // 1 s of blinking per event

// Must hold the larger of the two values above
`define CNT_BITS             27

`endif
